// File: files.f
+incdir+include
src/ks10BusPkg.sv
src/ks10MapPkg.sv
src/busArbiter.sv
src/pdpMemory.sv
src/ioStatusRegs.sv
src/ks10Backplane.sv
verification/clockGen.sv
verification/ks10BackplaneTb.sv

// File: Makefile
# Verilator build and run of the KS-10 backplane testbench

TOP = ks10BackplaneTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); \
	then \
		echo "Simulation FAILED"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: verification/ks10BackplaneTb.sv
/*
 * ks10BackplaneTb
 * Directed tests of the KS-10 backplane: memory preload and writes,
 * address decode, IO status registers and two-master arbitration.
 */
`default_nettype none

module ks10BackplaneTb;

   // Cycles to wait for an ack before giving up
   localparam int maxWait       = 16;
   // Watchdog budget
   localparam int numTests      = 5;
   localparam int cyclesPerTest = 400;
   localparam int margin        = 2;
   localparam int clkPeriod     = 4;

   logic                 clk;
   logic                 rstN;
   logic                 clken;
   logic                 cpuReq;
   ks10BusPkg::ks10AddrU cpuAddr;
   ks10BusPkg::busWordT  cpuDataW;
   logic                 cpuAck;
   ks10BusPkg::busWordT  cpuDataR;
   logic                 conReq;
   ks10BusPkg::ks10AddrU conAddr;
   ks10BusPkg::busWordT  conDataW;
   logic                 conAck;
   ks10BusPkg::busWordT  conDataR;
   ks10BusPkg::busWordT  switches;

   // Reference memory, same preload as the DUT
   ks10BusPkg::busWordT ram [0:ks10MapPkg::memWords-1];
   // Expected IO registers, slot 1 unused
   ks10BusPkg::busWordT ioModel [0:3];

   int seed = 32'hbfbb_1042;
   int wordErrors;
   int ackErrors;

   clockGen clocks
   (
      .clk  (clk),
      .rstN (rstN)
   );

   ks10Backplane dut_i
   (
      .clk      (clk),
      .rstN     (rstN),
      .clken    (clken),
      .cpuReq   (cpuReq),
      .cpuAddr  (cpuAddr),
      .cpuDataW (cpuDataW),
      .cpuAck   (cpuAck),
      .cpuDataR (cpuDataR),
      .conReq   (conReq),
      .conAddr  (conAddr),
      .conDataW (conDataW),
      .conAck   (conAck),
      .conDataR (conDataR),
      .switches (switches)
   );

   initial
   begin
      `include "memInit.svh"
   end

   //////////////////////////////////////////////////
   // Address words and random data
   //////////////////////////////////////////////////

   function automatic ks10BusPkg::ks10AddrU memAddr(input logic [21:0] phys, input logic write);
      ks10BusPkg::ks10AddrU a;
      a.word = '0;
      a.memView.flags[ks10BusPkg::flagRead]  = ~write;
      a.memView.flags[ks10BusPkg::flagWrite] = write;
      a.memView.physAddr = phys;
      return a;
   endfunction

   function automatic ks10BusPkg::ks10AddrU ioAddr(input logic [3:0] ctl,
                                                   input logic [1:0] regNum,
                                                   input logic write);
      ks10BusPkg::ks10AddrU a;
      a.word = '0;
      a.ioView.flags[ks10BusPkg::flagIo]    = 1'b1;
      a.ioView.flags[ks10BusPkg::flagRead]  = ~write;
      a.ioView.flags[ks10BusPkg::flagWrite] = write;
      a.ioView.ctlNum  = ctl;
      a.ioView.regAddr = ks10MapPkg::ioRegBase + 18'(regNum);
      return a;
   endfunction

   function automatic ks10BusPkg::busWordT randWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      return {hi[3:0], lo};
   endfunction

   // Switches slot reads the live input
   function automatic ks10BusPkg::busWordT ioExpect(input logic [1:0] regNum);
      if (regNum == ks10MapPkg::ioRegSwitches)
         return switches;
      return ioModel[regNum];
   endfunction

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic checkWord(input string what, input ks10BusPkg::busWordT got,
                            input ks10BusPkg::busWordT exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got %h, expected %h", what, got, exp);
         wordErrors++;
      end
   endtask

   task automatic checkAck(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got %h, expected %h", what, got, exp);
         ackErrors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Master drive
   //////////////////////////////////////////////////

   // Step to just after the next rising edge
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic driveMaster(input logic useCon, input logic req,
                              input ks10BusPkg::ks10AddrU addr,
                              input ks10BusPkg::busWordT data);
      if (useCon)
      begin
         conReq   = req;
         conAddr  = addr;
         conDataW = data;
      end
      else
      begin
         cpuReq   = req;
         cpuAddr  = addr;
         cpuDataW = data;
      end
   endtask

   // Ack sampled once per cycle, bounded by maxWait
   task automatic waitAck(input logic useCon, output logic acked);
      int waited;
      acked  = 1'b0;
      waited = 0;
      while (!acked && waited < maxWait)
      begin
         nextCycle();
         acked = useCon ? conAck : cpuAck;
         waited++;
      end
   endtask

   // Full request: raise, wait for ack, one enabled cycle, drop
   task automatic busAccess(input logic useCon, input ks10BusPkg::ks10AddrU addr,
                            input ks10BusPkg::busWordT wData, output logic acked,
                            output ks10BusPkg::busWordT rData);
      nextCycle();
      driveMaster(useCon, 1'b1, addr, wData);
      waitAck(useCon, acked);
      if (acked)
         nextCycle();
      // Data of the enabled cycle is now at dataR
      rData = useCon ? conDataR : cpuDataR;
      driveMaster(useCon, 1'b0, addr, wData);
   endtask

   task automatic readCheck(input logic useCon, input ks10BusPkg::ks10AddrU addr,
                            input ks10BusPkg::busWordT exp);
      logic                acked;
      ks10BusPkg::busWordT rData;
      busAccess(useCon, addr, '0, acked, rData);
      checkAck(useCon ? "conAck" : "cpuAck", acked, 1'b1);
      if (acked)
         checkWord(useCon ? "conDataR" : "cpuDataR", rData, exp);
   endtask

   task automatic writeMem(input logic [14:0] idx, input ks10BusPkg::busWordT data);
      logic                acked;
      ks10BusPkg::busWordT rData;
      busAccess(1'b0, memAddr(22'(idx), 1'b1), data, acked, rData);
      checkAck("cpuAck", acked, 1'b1);
      ram[idx] = data;
   endtask

   task automatic writeIo(input logic useCon, input logic [1:0] regNum,
                          input ks10BusPkg::busWordT data);
      logic                acked;
      ks10BusPkg::busWordT rData;
      busAccess(useCon, ioAddr(ks10MapPkg::ioCtlNum, regNum, 1'b1), data, acked, rData);
      checkAck(useCon ? "conAck" : "cpuAck", acked, 1'b1);
      if (regNum != ks10MapPkg::ioRegSwitches)
         ioModel[regNum] = data;
   endtask

   // Granted write held only across disabled clocks
   task automatic blockedWrite(input logic [14:0] idx, input ks10BusPkg::busWordT data);
      logic acked;
      nextCycle();
      driveMaster(1'b0, 1'b1, memAddr(22'(idx), 1'b1), data);
      waitAck(1'b0, acked);
      checkAck("cpuAck", acked, 1'b1);
      clken = 1'b0;
      repeat (3) nextCycle();
      driveMaster(1'b0, 1'b0, memAddr(22'(idx), 1'b1), data);
      clken = 1'b1;
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic testPreload();
      logic [14:0] list [9];
      list = '{15'o00000, 15'o00001, 15'o00002, 15'o00005, 15'o00140,
               15'o01003, 15'o02001, 15'o02003, 15'o77777};
      foreach (list[i])
         readCheck(1'b0, memAddr(22'(list[i]), 1'b0), ram[list[i]]);
   endtask

   task automatic testWriteRead();
      logic [14:0] idx [8];
      foreach (idx[i])
      begin
         idx[i] = 15'($random(seed));
         writeMem(idx[i], randWord());
      end
      foreach (idx[i])
         readCheck(1'b0, memAddr(22'(idx[i]), 1'b0), ram[idx[i]]);
      // Location keeps its old word
      blockedWrite(15'o02000, ~ram[15'o02000]);
      readCheck(1'b0, memAddr(22'o02000, 1'b0), ram[15'o02000]);
   endtask

   task automatic testNoAck();
      logic                acked;
      ks10BusPkg::busWordT rData;
      // First word past the implemented size, aliases index 0
      busAccess(1'b0, memAddr(22'(ks10MapPkg::memWords), 1'b1), randWord(), acked, rData);
      checkAck("cpuAck", acked, 1'b0);
      readCheck(1'b0, memAddr(22'o0, 1'b0), ram[0]);
      busAccess(1'b0, memAddr(22'o3777777, 1'b0), '0, acked, rData);
      checkAck("cpuAck", acked, 1'b0);
      // Wrong controller numbers
      busAccess(1'b0, ioAddr(ks10MapPkg::ioCtlNum + 4'd1, 2'd0, 1'b0), '0, acked, rData);
      checkAck("cpuAck", acked, 1'b0);
      busAccess(1'b1, ioAddr(4'd0, 2'd2, 1'b1), randWord(), acked, rData);
      checkAck("conAck", acked, 1'b0);
   endtask

   task automatic testIoRegs();
      logic [1:0] rwRegs [3];
      rwRegs = '{2'd0, 2'd2, 2'd3};
      // Read/write registers come out of reset at zero
      foreach (rwRegs[i])
         readCheck(1'b0, ioAddr(ks10MapPkg::ioCtlNum, rwRegs[i], 1'b0), '0);
      for (int r = 0; r < 4; r++)
         writeIo(1'b0, 2'(r), randWord());
      for (int r = 0; r < 4; r++)
         readCheck(1'b0, ioAddr(ks10MapPkg::ioCtlNum, 2'(r), 1'b0), ioExpect(2'(r)));
      // New switch setting read through the console port
      switches = 36'o765432_012345;
      readCheck(1'b1, ioAddr(ks10MapPkg::ioCtlNum, ks10MapPkg::ioRegSwitches, 1'b0),
                switches);
   endtask

   task automatic testArbitration();
      logic acked;
      // Both request from idle
      nextCycle();
      driveMaster(1'b1, 1'b1, memAddr(22'o01001, 1'b0), '0);
      driveMaster(1'b0, 1'b1, ioAddr(ks10MapPkg::ioCtlNum, 2'd2, 1'b0), '0);
      waitAck(1'b1, acked);
      checkAck("conAck", acked, 1'b1);
      checkAck("cpuAck", cpuAck, 1'b0);
      nextCycle();
      checkWord("conDataR", conDataR, ram[15'o01001]);
      checkAck("cpuAck", cpuAck, 1'b0);
      driveMaster(1'b1, 1'b0, memAddr(22'o01001, 1'b0), '0);
      // CPU takes over once con lets go
      waitAck(1'b0, acked);
      checkAck("cpuAck", acked, 1'b1);
      checkAck("conAck", conAck, 1'b0);
      nextCycle();
      checkWord("cpuDataR", cpuDataR, ioExpect(2'd2));
      driveMaster(1'b0, 1'b0, ioAddr(ks10MapPkg::ioCtlNum, 2'd2, 1'b0), '0);

      // Locked CPU grant holds off the console
      nextCycle();
      driveMaster(1'b0, 1'b1, memAddr(22'o02002, 1'b0), '0);
      waitAck(1'b0, acked);
      checkAck("cpuAck", acked, 1'b1);
      driveMaster(1'b1, 1'b1, memAddr(22'o00141, 1'b0), '0);
      nextCycle();
      checkAck("cpuAck", cpuAck, 1'b1);
      checkAck("conAck", conAck, 1'b0);
      checkWord("cpuDataR", cpuDataR, ram[15'o02002]);
      driveMaster(1'b0, 1'b0, memAddr(22'o02002, 1'b0), '0);
      waitAck(1'b1, acked);
      checkAck("conAck", acked, 1'b1);
      nextCycle();
      checkWord("conDataR", conDataR, ram[15'o00141]);
      driveMaster(1'b1, 1'b0, memAddr(22'o00141, 1'b0), '0);
   endtask

   //////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////

   initial
   begin
      clken      = 1'b1;
      cpuReq     = 1'b0;
      cpuAddr    = '0;
      cpuDataW   = '0;
      conReq     = 1'b0;
      conAddr    = '0;
      conDataW   = '0;
      switches   = 36'o123321_456654;
      wordErrors = 0;
      ackErrors  = 0;
      for (int r = 0; r < 4; r++)
         ioModel[r] = '0;
      wait (rstN === 1'b1);
      testPreload();
      testWriteRead();
      testNoAck();
      testIoRegs();
      testArbitration();
      nextCycle();
      $display("Errors: data %0d, ack %0d", wordErrors, ackErrors);
      if (wordErrors + ackErrors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   initial
   begin
      #(numTests * cyclesPerTest * margin * clkPeriod);
      $display("Watchdog timeout, the tests did not finish in time");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/clockGen.sv
/*
 * clockGen
 * Testbench clock, period 4, and active-low reset held
 * for the first two rising edges.
 */
`default_nettype none

module clockGen
(
   output logic clk,
   output logic rstN
);

   localparam int halfPeriod  = 2;
   localparam int resetCycles = 2;

   // Free-running clock
   initial
   begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   // Release just after an edge
   initial
   begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      #1 rstN = 1'b1;
   end

endmodule

`default_nettype wire

// File: src/ks10Backplane.sv
/*
 * ks10Backplane
 * CPU and console masters sharing one backplane through the
 * arbiter, with PDP-10 memory and the IO status registers.
 */
`default_nettype none

module ks10Backplane
(
   input  wire logic                 clk,
   input  wire logic                 rstN,
   input  wire logic                 clken,
   // CPU port
   input  wire logic                 cpuReq,
   input  wire ks10BusPkg::ks10AddrU cpuAddr,
   input  wire ks10BusPkg::busWordT  cpuDataW,
   output logic                      cpuAck,
   output ks10BusPkg::busWordT       cpuDataR,
   // Console port
   input  wire logic                 conReq,
   input  wire ks10BusPkg::ks10AddrU conAddr,
   input  wire ks10BusPkg::busWordT  conDataW,
   output logic                      conAck,
   output ks10BusPkg::busWordT       conDataR,
   // Console switches
   input  wire ks10BusPkg::busWordT  switches
);

   // Shared backplane
   logic                 busReq;
   ks10BusPkg::ks10AddrU busAddr;
   ks10BusPkg::busWordT  busDataW;

   // Slave returns
   logic                 memAck;
   logic                 ioAck;
   ks10BusPkg::busWordT  memData;
   ks10BusPkg::busWordT  ioData;

   //////////////////////////////////////////////////
   // Arbiter
   //////////////////////////////////////////////////

   busArbiter arbiter
   (
      .clk      (clk),
      .rstN     (rstN),
      .clken    (clken),
      .cpuReq   (cpuReq),
      .conReq   (conReq),
      .cpuAddr  (cpuAddr),
      .conAddr  (conAddr),
      .cpuDataW (cpuDataW),
      .conDataW (conDataW),
      .cpuAck   (cpuAck),
      .conAck   (conAck),
      .cpuDataR (cpuDataR),
      .conDataR (conDataR),
      .busReq   (busReq),
      .busAddr  (busAddr),
      .busDataW (busDataW),
      .memAck   (memAck),
      .ioAck    (ioAck),
      .memData  (memData),
      .ioData   (ioData)
   );

   //////////////////////////////////////////////////
   // Slaves
   //////////////////////////////////////////////////

   // Memory has no reset
   pdpMemory memory
   (
      .clk      (clk),
      .clken    (clken),
      .busReq   (busReq),
      .busAddr  (busAddr),
      .busDataW (busDataW),
      .memAck   (memAck),
      .memData  (memData)
   );

   ioStatusRegs statusRegs
   (
      .clk      (clk),
      .rstN     (rstN),
      .clken    (clken),
      .busReq   (busReq),
      .busAddr  (busAddr),
      .busDataW (busDataW),
      .switches (switches),
      .ioAck    (ioAck),
      .ioData   (ioData)
   );

endmodule

`default_nettype wire

// File: src/ioStatusRegs.sv
/*
 * ioStatusRegs
 * Four 36-bit IO registers at one controller number.
 * Register 1 returns the console switches.
 */
`default_nettype none

module ioStatusRegs
(
   input  wire logic                 clk,
   input  wire logic                 rstN,
   input  wire logic                 clken,
   input  wire logic                 busReq,
   input  wire ks10BusPkg::ks10AddrU busAddr,
   input  wire ks10BusPkg::busWordT  busDataW,
   input  wire ks10BusPkg::busWordT  switches,
   output logic                      ioAck,
   output ks10BusPkg::busWordT       ioData
);

   // Read/write registers
   ks10BusPkg::busWordT ioReg0;
   ks10BusPkg::busWordT ioReg2;
   ks10BusPkg::busWordT ioReg3;
   ks10BusPkg::busWordT readWord;

   logic [17:0] regOffset;
   logic [1:0]  regIdx;
   logic        regHit;
   logic        ctlHit;
   logic        access;
   logic        wrEn;
   logic        rdEn;

   //////////////////////////////////////////////////
   // IO address decode
   //////////////////////////////////////////////////

   // Offset from the first register
   assign regOffset = busAddr.ioView.regAddr - ks10MapPkg::ioRegBase;
   assign regHit    = regOffset[17:2] == 16'd0;
   assign regIdx    = regOffset[1:0];
   assign ctlHit    = busAddr.ioView.ctlNum == ks10MapPkg::ioCtlNum;

   // IO flag, controller and register window
   assign ioAck = busAddr.ioView.flags[ks10BusPkg::flagIo] & ctlHit & regHit;

   assign access = clken & busReq & ioAck;
   assign wrEn   = access & busAddr.ioView.flags[ks10BusPkg::flagWrite];
   assign rdEn   = access & busAddr.ioView.flags[ks10BusPkg::flagRead];

   //////////////////////////////////////////////////
   // Registers
   //////////////////////////////////////////////////

   // Switches slot ignores writes
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         ioReg0 <= '0;
         ioReg2 <= '0;
         ioReg3 <= '0;
      end
      else if (wrEn)
      begin
         case (regIdx)
            2'd0:    ioReg0 <= busDataW;
            2'd2:    ioReg2 <= busDataW;
            2'd3:    ioReg3 <= busDataW;
            default: ;
         endcase
      end
   end

   // Read select
   always_comb
   begin
      case (regIdx)
         ks10MapPkg::ioRegSwitches: readWord = switches;
         2'd0:                      readWord = ioReg0;
         2'd2:                      readWord = ioReg2;
         default:                   readWord = ioReg3;
      endcase
   end

   // Read data one enabled clock later
   always_ff @(posedge clk)
   begin
      if (rdEn)
         ioData <= readWord;
   end

endmodule

`default_nettype wire

// File: src/pdpMemory.sv
/*
 * pdpMemory
 * 32K words of 36-bit PDP-10 memory on the KS-10 backplane.
 * Acks implemented non-IO addresses, read data one enabled clock later.
 */
`default_nettype none

module pdpMemory
(
   input  wire logic                 clk,
   input  wire logic                 clken,
   input  wire logic                 busReq,
   input  wire ks10BusPkg::ks10AddrU busAddr,
   input  wire ks10BusPkg::busWordT  busDataW,
   output logic                      memAck,
   output ks10BusPkg::busWordT       memData
);

   // Preloaded word array
   ks10BusPkg::busWordT ram [0:ks10MapPkg::memWords-1];

   // Low bits of the physical address
   logic [ks10MapPkg::memAddrBits-1:0] wrIdx;
   // Captured on an enabled access
   logic [ks10MapPkg::memAddrBits-1:0] rdIdx;

   logic isIo;
   logic inRange;
   logic isWrite;
   logic access;

   //////////////////////////////////////////////////
   // Preload
   //////////////////////////////////////////////////

   // Diagnostic image instead of a loader
   initial
   begin
      `include "memInit.svh"
   end

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   assign isIo    = busAddr.memView.flags[ks10BusPkg::flagIo];
   assign isWrite = busAddr.memView.flags[ks10BusPkg::flagWrite];
   assign inRange = busAddr.memView.physAddr < 22'(ks10MapPkg::memWords);
   assign wrIdx   = busAddr.memView.physAddr[36-ks10MapPkg::memAddrBits:35];

   // Ack from the address alone
   assign memAck = ~isIo & inRange;

   // Enabled and selected
   assign access = clken & busReq & memAck;

   //////////////////////////////////////////////////
   // Synchronous RAM
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (access)
      begin
         if (isWrite)
            ram[wrIdx] <= busDataW;
         rdIdx <= wrIdx;
      end
   end

   // Holds until the next memory access
   assign memData = ram[rdIdx];

endmodule

`default_nettype wire

// File: src/busArbiter.sv
/*
 * busArbiter
 * Two-master KS-10 backplane arbiter. Console wins from idle,
 * a grant stays locked while its request is held, and slave
 * responses are routed back to the granted master.
 */
`default_nettype none

module busArbiter
(
   input  wire logic                 clk,
   input  wire logic                 rstN,
   input  wire logic                 clken,
   // Masters
   input  wire logic                 cpuReq,
   input  wire logic                 conReq,
   input  wire ks10BusPkg::ks10AddrU cpuAddr,
   input  wire ks10BusPkg::ks10AddrU conAddr,
   input  wire ks10BusPkg::busWordT  cpuDataW,
   input  wire ks10BusPkg::busWordT  conDataW,
   output logic                      cpuAck,
   output logic                      conAck,
   output ks10BusPkg::busWordT       cpuDataR,
   output ks10BusPkg::busWordT       conDataR,
   // Backplane
   output logic                      busReq,
   output ks10BusPkg::ks10AddrU      busAddr,
   output ks10BusPkg::busWordT       busDataW,
   // Slave returns
   input  wire logic                 memAck,
   input  wire logic                 ioAck,
   input  wire ks10BusPkg::busWordT  memData,
   input  wire ks10BusPkg::busWordT  ioData
);

   // One-hot grant, both low when idle
   logic grantCon;
   logic grantCpu;
   logic nextCon;
   logic nextCpu;
   // High when the IO slave answered last
   logic respIo;
   logic slaveAck;
   ks10BusPkg::busWordT respData;

   //////////////////////////////////////////////////
   // Grant
   //////////////////////////////////////////////////

   // Re-arbitrate only when the granted request has dropped
   always_comb
   begin
      nextCon = grantCon;
      nextCpu = grantCpu;
      if (!busReq)
      begin
         // Console first
         nextCon = conReq;
         nextCpu = cpuReq & ~conReq;
      end
   end

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         grantCon <= 1'b0;
         grantCpu <= 1'b0;
      end
      else if (clken)
      begin
         grantCon <= nextCon;
         grantCpu <= nextCpu;
      end
   end

   //////////////////////////////////////////////////
   // Backplane drive
   //////////////////////////////////////////////////

   // Request of the granted master only
   assign busReq   = (grantCon & conReq) | (grantCpu & cpuReq);
   assign busAddr  = grantCon ? conAddr  : cpuAddr;
   assign busDataW = grantCon ? conDataW : cpuDataW;

   // Slave decodes are mutually exclusive
   assign slaveAck = memAck | ioAck;

   // Ungranted master sees no ack and keeps waiting
   assign conAck = grantCon & slaveAck;
   assign cpuAck = grantCpu & slaveAck;

   //////////////////////////////////////////////////
   // Response routing
   //////////////////////////////////////////////////

   // Remember who answered the last enabled access
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         respIo <= 1'b0;
      else if (clken & busReq & slaveAck)
         respIo <= ioAck;
   end

   assign respData = respIo ? ioData : memData;

   // Shared return path
   // Valid for whichever master made the last access
   assign conDataR = respData;
   assign cpuDataR = respData;

endmodule

`default_nettype wire

// File: src/ks10MapPkg.sv
/*
 * KS-10 backplane address map
 * Implemented memory size and the IO slave location.
 */
`default_nettype none

package ks10MapPkg;

   //////////////////////////////////////////////////
   // Memory
   //////////////////////////////////////////////////

   // Only 32K words implemented
   localparam int memWords    = 32768;
   // Index width into the memory array
   localparam int memAddrBits = 15;

   //////////////////////////////////////////////////
   // IO status registers
   //////////////////////////////////////////////////

   // Controller number of the status register block
   localparam logic [3:0]  ioCtlNum      = 4'd3;
   // First of four consecutive register addresses
   localparam logic [17:0] ioRegBase     = 18'o000200;
   // Read-only console switches
   localparam logic [1:0]  ioRegSwitches = 2'd1;

endpackage

`default_nettype wire

// File: src/ks10BusPkg.sv
/*
 * KS-10 bus word formats
 * Word type, flag bit positions and the two decodes of the
 * backplane address word.
 */
`default_nettype none

package ks10BusPkg;

   //////////////////////////////////////////////////
   // Word format
   //////////////////////////////////////////////////

   // PDP-10 numbering, bit 0 is the MSB
   typedef logic [0:35] busWordT;

   //////////////////////////////////////////////////
   // Address word flags
   //////////////////////////////////////////////////

   // Bit positions inside the 14-bit flags field
   localparam int flagRead  = 3;
   localparam int flagWrite = 5;
   localparam int flagIo    = 10;

   //////////////////////////////////////////////////
   // Address word decodes
   //////////////////////////////////////////////////

   typedef union packed
   {
      // Raw 36-bit word
      busWordT word;
      // Memory cycle
      struct packed
      {
         logic [0:13]  flags;
         logic [14:35] physAddr;
      } memView;
      // IO cycle
      struct packed
      {
         logic [0:13]  flags;
         logic [14:17] ctlNum;
         logic [18:35] regAddr;
      } ioView;
   } ks10AddrU;

endpackage

`default_nettype wire

// File: include/memInit.svh
/*
 * PDP-10 memory preload image
 * Word assignments into the array ram, included inside an
 * initial block of the memory and of the testbench model.
 */

// Low core
ram[15'o00000] = 36'o000000_000000;
ram[15'o00001] = 36'o777777_777777;
ram[15'o00002] = 36'o252525_252525;
ram[15'o00003] = 36'o525252_525252;
ram[15'o00004] = 36'o000001_000001;
ram[15'o00005] = 36'o400000_000000;

// Start vector
ram[15'o00140] = 36'o254000_001000;
ram[15'o00141] = 36'o254200_000141;

// Small test loop at 1000
ram[15'o01000] = 36'o201000_000000;
ram[15'o01001] = 36'o201040_000017;
ram[15'o01002] = 36'o271000_000001;
ram[15'o01003] = 36'o367040_001002;
ram[15'o01004] = 36'o302000_000017;
ram[15'o01005] = 36'o254200_001005;
ram[15'o01006] = 36'o254000_001000;

// Data table
ram[15'o02000] = 36'o123456_701234;
ram[15'o02001] = 36'o765432_107654;
ram[15'o02002] = 36'o000777_000777;
ram[15'o02003] = 36'o777000_777000;

// Top of implemented memory
ram[15'o77776] = 36'o707070_707070;
ram[15'o77777] = 36'o070707_070707;
